/* Makefile */
# Verilator flow for the APB serial port: build and run, lint, clean

TOP := tb_uart_apb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): uart_apb.f design/*.sv verif/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f uart_apb.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f uart_apb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* design/uart_apb_regs.sv */
// zero-wait apb slave, 4-bit byte address, no byte strobes; pslverr writes change nothing
`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs import uart_pkg::*; #(
	parameter divisor_t DEFAULT_DIVISOR = 16'd4
) (
	input  wire       sys_clk,
	input  wire       sys_rst,
	input  apb_addr_t paddr,
	input  wire       psel,
	input  wire       penable,
	input  wire       pwrite,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	uart_link_if.regs link
);

	//----------------------------------------------------------------------
	// access phase decode
	//----------------------------------------------------------------------
	logic access;
	logic addr_hit;
	logic wr_ok;
	logic data_wr;
	logic data_rd;
	logic status_wr;
	logic divisor_wr;

	// register state
	logic     tx_busy;
	logic     rx_valid;
	logic     rx_overrun;
	byte_t    rx_byte;
	byte_t    tx_byte;
	divisor_t divisor_q;
	logic     tx_wr_q;
	apb_data_t status_word;

	assign access   = psel && penable;
	assign addr_hit = (paddr == ADDR_DATA) || (paddr == ADDR_STATUS) ||
		(paddr == ADDR_DIVISOR);

	assign pready  = psel; // never waits
	assign pslverr = access && (!addr_hit ||
		(pwrite && paddr == ADDR_DATA && tx_busy)); // unmapped, or tx refused

	assign wr_ok      = access && pwrite && !pslverr;
	assign data_wr    = wr_ok && (paddr == ADDR_DATA);
	assign status_wr  = wr_ok && (paddr == ADDR_STATUS);
	assign divisor_wr = wr_ok && (paddr == ADDR_DIVISOR);
	assign data_rd    = access && !pwrite && (paddr == ADDR_DATA);

	//----------------------------------------------------------------------
	// read mux
	//----------------------------------------------------------------------
	always_comb begin
		status_word = '0;
		status_word[STAT_TX_BUSY]    = tx_busy;
		status_word[STAT_RX_VALID]   = rx_valid;
		status_word[STAT_RX_OVERRUN] = rx_overrun;
	end

	always_comb begin
		prdata = '0;
		if (access) begin
			case (paddr)
				ADDR_DATA:    prdata = {24'd0, rx_byte};
				ADDR_STATUS:  prdata = status_word;
				ADDR_DIVISOR: prdata = {16'd0, divisor_q};
				default:      prdata = '0; // pslverr covers it
			endcase
		end
	end

	//----------------------------------------------------------------------
	// control flags
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			divisor_q  <= DEFAULT_DIVISOR;
			tx_busy    <= 1'b0;
			tx_wr_q    <= 1'b0;
			rx_valid   <= 1'b0;
			rx_overrun <= 1'b0;
		end else begin
			tx_wr_q <= data_wr; // launch one cycle after the write
			if (divisor_wr)
				divisor_q <= pwdata[15:0];

			// busy from accepted write to one cycle past tx_done
			if (data_wr)
				tx_busy <= 1'b1;
			else if (link.tx_done)
				tx_busy <= 1'b0;

			// a new byte beats a read in the same cycle
			if (link.rx_done)
				rx_valid <= 1'b1;
			else if (data_rd)
				rx_valid <= 1'b0;

			if (link.rx_done && rx_valid && !data_rd)
				rx_overrun <= 1'b1; // unread byte lost
			else if (status_wr && pwdata[STAT_RX_OVERRUN])
				rx_overrun <= 1'b0;
		end
	end

	// payload bytes
	always_ff @(posedge sys_clk) begin
		if (data_wr)
			tx_byte <= pwdata[7:0];
		if (link.rx_done)
			rx_byte <= link.rx_data; // newest byte wins
	end

	assign link.divisor = divisor_q;
	assign link.tx_data = tx_byte;
	assign link.tx_wr   = tx_wr_q;

endmodule

`default_nettype wire

/* design/uart_apb_top.sv */
// serial port top; divisor must be nonzero, line runs at sys_clk / (16 * divisor)
`timescale 1ns/1ps
`default_nettype none

module uart_apb_top import uart_pkg::*; #(
	parameter divisor_t DEFAULT_DIVISOR = 16'd4 // reset baud setting
) (
	input  wire       sys_clk,
	input  wire       sys_rst,

	// apb slave
	input  apb_addr_t paddr,
	input  wire       psel,
	input  wire       penable,
	input  wire       pwrite,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,

	// serial line
	input  wire       uart_rxd,
	output logic      uart_txd
);

	//----------------------------------------------------------------------
	// regs to transceiver link
	//----------------------------------------------------------------------
	uart_link_if link ();

	uart_apb_regs #(
		.DEFAULT_DIVISOR(DEFAULT_DIVISOR)
	) u_regs (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.link    (link.regs)
	);

	// 8N1 line side
	uart_transceiver u_xcvr (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.uart_rxd (uart_rxd),
		.uart_txd (uart_txd),
		.link     (link.line)
	);

endmodule

`default_nettype wire

/* design/uart_link_if.sv */
// link between register block and line transceiver; all three strobes are one-cycle pulses
`timescale 1ns/1ps
`default_nettype none

interface uart_link_if import uart_pkg::*; ();

	// register block to transceiver
	divisor_t divisor; // sys_clk cycles per 16x tick
	byte_t    tx_data; // stable while tx busy
	logic     tx_wr;   // only issued with tx busy clear

	// transceiver to register block
	logic     tx_done; // end of stop bit
	byte_t    rx_data; // valid with rx_done
	logic     rx_done; // good stop bit only

	modport regs (
		output divisor,
		output tx_data,
		output tx_wr,
		input  tx_done,
		input  rx_data,
		input  rx_done
	);

	modport line (
		input  divisor,
		input  tx_data,
		input  tx_wr,
		output tx_done,
		output rx_data,
		output rx_done
	);

endinterface

`default_nettype wire

/* design/uart_pkg.sv */
// shared widths, register map and status bits; register offsets assume a 4-bit byte address
`default_nettype none

package uart_pkg;

	//----------------------------------------------------------------------
	// widths with a meaning
	//----------------------------------------------------------------------
	typedef logic [7:0]  byte_t;     // one serial character
	typedef logic [15:0] divisor_t;  // sys_clk cycles per 16x tick
	typedef logic [3:0]  apb_addr_t; // register byte address
	typedef logic [31:0] apb_data_t; // apb data word

	// register offsets
	localparam apb_addr_t ADDR_DATA    = 4'h0; // tx on write, rx on read
	localparam apb_addr_t ADDR_STATUS  = 4'h4;
	localparam apb_addr_t ADDR_DIVISOR = 4'h8;

	// status bit positions
	localparam int STAT_TX_BUSY    = 0;
	localparam int STAT_RX_VALID   = 1;
	localparam int STAT_RX_OVERRUN = 2; // write 1 to clear

	//----------------------------------------------------------------------
	// transceiver fsm states
	//----------------------------------------------------------------------
	typedef enum logic {
		RX_IDLE,  // hunting for a start bit
		RX_FRAME  // start seen, sampling bits
	} rx_state_t;

	typedef enum logic {
		TX_IDLE,
		TX_FRAME  // start, data and stop on the line
	} tx_state_t;

endpackage

`default_nettype wire

/* design/uart_transceiver.sv */
// 8N1 only, no parity or framing error report; divisor 0 acts as 65536; tx_wr restarts a frame
`timescale 1ns/1ps
`default_nettype none

module uart_transceiver import uart_pkg::*; (
	input  wire  sys_clk,
	input  wire  sys_rst,
	input  wire  uart_rxd,
	output logic uart_txd,
	uart_link_if.line link
);

	//----------------------------------------------------------------------
	// 16x oversampling tick
	//----------------------------------------------------------------------
	divisor_t tick_cnt;
	logic enable16;

	assign enable16 = (tick_cnt == '0); // one cycle every divisor cycles

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tick_cnt <= link.divisor - divisor_t'(1);
		end else if (enable16) begin
			tick_cnt <= link.divisor - divisor_t'(1); // reload, picks up new divisor
		end else begin
			tick_cnt <= tick_cnt - divisor_t'(1);
		end
	end

	//----------------------------------------------------------------------
	// rx input synchronizer
	//----------------------------------------------------------------------
	logic rxd_s1;
	logic rxd_s2;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rxd_s1 <= 1'b1; // idle line level
			rxd_s2 <= 1'b1;
		end else begin
			rxd_s1 <= uart_rxd;
			rxd_s2 <= rxd_s1;
		end
	end

	//----------------------------------------------------------------------
	// receiver
	//----------------------------------------------------------------------
	rx_state_t rx_state;
	logic [3:0] rx_count16;  // ticks within a bit
	logic [3:0] rx_bitcount; // 0 start, 1..8 data, 9 stop
	byte_t rxd_reg;
	logic rx_sample;

	// mid-bit sample point
	assign rx_sample = enable16 && (rx_state == RX_FRAME) && (rx_count16 == 4'd0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rx_state    <= RX_IDLE;
			rx_count16  <= 4'd0;
			rx_bitcount <= 4'd0;
			link.rx_done <= 1'b0;
		end else begin
			link.rx_done <= 1'b0;
			if (enable16) begin
				case (rx_state)
					RX_IDLE: begin
						if (!rxd_s2) begin // falling edge, maybe a start bit
							rx_state    <= RX_FRAME;
							rx_count16  <= 4'd7; // first sample lands mid start bit
							rx_bitcount <= 4'd0;
						end
					end
					RX_FRAME: begin
						rx_count16 <= rx_count16 + 4'd1;
						if (rx_count16 == 4'd0) begin
							rx_bitcount <= rx_bitcount + 4'd1;
							if (rx_bitcount == 4'd0) begin
								if (rxd_s2)
									rx_state <= RX_IDLE; // glitch, start bit gone
							end else if (rx_bitcount == 4'd9) begin
								rx_state <= RX_IDLE;
								link.rx_done <= rxd_s2; // bad stop bit dropped
							end
						end
					end
					default: rx_state <= RX_IDLE;
				endcase
			end
		end
	end

	// rx payload, lsb first
	always_ff @(posedge sys_clk) begin
		if (rx_sample) begin
			if (rx_bitcount == 4'd9)
				link.rx_data <= rxd_reg; // only seen by regs with rx_done
			else if (rx_bitcount != 4'd0)
				rxd_reg <= {rxd_s2, rxd_reg[7:1]};
		end
	end

	//----------------------------------------------------------------------
	// transmitter
	//----------------------------------------------------------------------
	tx_state_t tx_state;
	logic [3:0] tx_count16;
	logic [3:0] tx_bitcount; // bit currently ending
	byte_t txd_reg;
	logic tx_step;

	// bit boundary, a fresh tx_wr wins
	assign tx_step = !link.tx_wr && enable16 && (tx_state == TX_FRAME) &&
		(tx_count16 == 4'd0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tx_state    <= TX_IDLE;
			tx_count16  <= 4'd0;
			tx_bitcount <= 4'd0;
			uart_txd    <= 1'b1;
			link.tx_done <= 1'b0;
		end else begin
			link.tx_done <= 1'b0;
			if (link.tx_wr) begin
				tx_state    <= TX_FRAME;
				tx_count16  <= 4'd1; // start bit is one tick short at most
				tx_bitcount <= 4'd0;
				uart_txd    <= 1'b0; // start bit
			end else if (enable16 && tx_state == TX_FRAME) begin
				tx_count16 <= tx_count16 + 4'd1;
				if (tx_step) begin
					tx_bitcount <= tx_bitcount + 4'd1;
					if (tx_bitcount == 4'd8) begin
						uart_txd <= 1'b1; // stop bit
					end else if (tx_bitcount == 4'd9) begin
						uart_txd     <= 1'b1;
						tx_state     <= TX_IDLE;
						link.tx_done <= 1'b1; // stop bit complete
					end else begin
						uart_txd <= txd_reg[0];
					end
				end
			end
		end
	end

	// tx shift register
	always_ff @(posedge sys_clk) begin
		if (link.tx_wr)
			txd_reg <= link.tx_data;
		else if (tx_step && tx_bitcount < 4'd8)
			txd_reg <= {1'b0, txd_reg[7:1]}; // next data bit to [0]
	end

endmodule

`default_nettype wire

/* uart_apb.f */
design/uart_pkg.sv
design/uart_link_if.sv
design/uart_transceiver.sv
design/uart_apb_regs.sv
design/uart_apb_top.sv
verif/uart_apb_checker.sv
verif/tb_uart_apb.sv

/* verif/tb_uart_apb.sv */
// loopback testbench, uart_txd wired to uart_rxd; expects the divisor reset value overridden to 3
`timescale 1ns/1ps
`default_nettype none

module tb_uart_apb import uart_pkg::*; ();

	localparam int POLL_LIMIT = 2000; // status reads per wait
	localparam int EDGE_LIMIT = 200;  // cycles to see a start bit

	logic      sys_clk;
	logic      sys_rst;
	apb_addr_t paddr;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	wire       uart_txd; // looped back into uart_rxd

	uart_apb_top #(
		.DEFAULT_DIVISOR(16'd3)
	) u_uart_apb_top (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.uart_rxd (uart_txd),
		.uart_txd (uart_txd)
	);

	always #10 sys_clk = ~sys_clk; // 20 ns period

	//----------------------------------------------------------------------
	// reporting
	//----------------------------------------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	//----------------------------------------------------------------------
	// apb master
	//----------------------------------------------------------------------
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge sys_clk);
		psel    <= 1'b1; // setup phase
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge sys_clk);
		penable <= 1'b1; // access phase
		@(negedge sys_clk);
		err = pslverr; // mid access, stable
		check_value("pready", 32'(pready), 32'd1); // zero wait states
		@(posedge sys_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge sys_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge sys_clk);
		penable <= 1'b1;
		@(negedge sys_clk);
		data = prdata; // combinational in access phase
		err  = pslverr;
		check_value("pready", 32'(pready), 32'd1);
		@(posedge sys_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// poll one status flag until it reaches level
	task automatic wait_status(input int bit_pos, input logic level, input string what);
		apb_data_t stat;
		logic err;
		int tries;
		bit hit;
		tries = 0;
		hit = 1'b0;
		while (!hit && tries < POLL_LIMIT) begin
			apb_read(ADDR_STATUS, stat, err);
			hit = (stat[bit_pos] === level);
			tries++;
		end
		if (!hit)
			abort_run($sformatf("timed out waiting for %s", what));
	endtask

	task automatic send_byte(input byte_t value);
		logic err;
		apb_write(ADDR_DATA, {24'd0, value}, err);
		check_value("pslverr", 32'(err), 32'd0);
	endtask

	// receive, check, then let the frame finish
	task automatic expect_byte(input byte_t value);
		apb_data_t data;
		logic err;
		wait_status(STAT_RX_VALID, 1'b1, "rx valid");
		apb_read(ADDR_DATA, data, err);
		check_value("rx_data", data, {24'd0, value});
		wait_status(STAT_TX_BUSY, 1'b0, "tx busy to clear");
	endtask

	//----------------------------------------------------------------------
	// directed tests
	//----------------------------------------------------------------------
	task automatic check_reset_state();
		apb_data_t data;
		logic err;
		apb_read(ADDR_STATUS, data, err);
		check_value("status", data, 32'd0);
		check_value("pslverr", 32'(err), 32'd0);
		apb_read(ADDR_DIVISOR, data, err);
		check_value("divisor", data, 32'd3);
		@(negedge sys_clk);
		check_value("uart_txd", 32'(uart_txd), 32'd1); // idle line
	endtask

	task automatic run_loopback();
		apb_data_t data;
		logic err;
		send_byte(8'ha5);
		wait_status(STAT_RX_VALID, 1'b1, "rx valid after 0xa5");
		apb_read(ADDR_DATA, data, err);
		check_value("rx_data", data, 32'h0000_00a5);
		wait_status(STAT_TX_BUSY, 1'b0, "tx busy to clear");
		apb_read(ADDR_STATUS, data, err);
		check_value("status", data, 32'd0); // read cleared rx valid
	endtask

	task automatic measure_bit_timing();
		apb_data_t data;
		logic err;
		int div;
		int edges;
		int low_cycles;
		div = 5;
		apb_write(ADDR_DIVISOR, 32'(div), err);
		check_value("pslverr", 32'(err), 32'd0);
		send_byte(8'h5b); // lsb 1, so low time is the start bit alone
		edges = 0;
		@(negedge sys_clk);
		while (uart_txd !== 1'b0 && edges < EDGE_LIMIT) begin
			edges++;
			@(negedge sys_clk);
		end
		if (uart_txd !== 1'b0)
			abort_run("start bit never appeared on uart_txd");
		low_cycles = 0;
		while (uart_txd === 1'b0 && low_cycles < 1000) begin
			low_cycles++; // one cycle per negedge seen low
			@(negedge sys_clk);
		end
		if (low_cycles < 15 * div + 1 || low_cycles > 16 * div)
			abort_run($sformatf("ERROR start_bit_cycles got 0x%0h expected 0x%0h to 0x%0h",
				low_cycles, 15 * div + 1, 16 * div));
		expect_byte(8'h5b);
		apb_write(ADDR_DIVISOR, 32'd3, err); // back to the fast rate
		apb_read(ADDR_DIVISOR, data, err);
		check_value("divisor", data, 32'd3);
	endtask

	task automatic probe_errors();
		apb_data_t data;
		logic err;
		send_byte(8'h3c);
		apb_write(ADDR_DATA, 32'h0000_00c3, err);
		check_value("pslverr", 32'(err), 32'd1); // still busy
		expect_byte(8'h3c);
		apb_read(ADDR_STATUS, data, err);
		check_value("status", data, 32'd0); // refused byte never went out
		apb_read(4'hc, data, err);
		check_value("pslverr", 32'(err), 32'd1);
		apb_write(4'hc, 32'hffff_ffff, err);
		check_value("pslverr", 32'(err), 32'd1);
	endtask

	task automatic force_overrun();
		apb_data_t data;
		apb_data_t expected;
		logic err;
		send_byte(8'h11);
		wait_status(STAT_RX_VALID, 1'b1, "first byte");
		wait_status(STAT_TX_BUSY, 1'b0, "tx busy to clear");
		send_byte(8'h22); // first byte left unread
		wait_status(STAT_RX_OVERRUN, 1'b1, "rx overrun");
		wait_status(STAT_TX_BUSY, 1'b0, "tx busy to clear");
		expected = '0;
		expected[STAT_RX_VALID]   = 1'b1;
		expected[STAT_RX_OVERRUN] = 1'b1;
		apb_read(ADDR_STATUS, data, err);
		check_value("status", data, expected);
		apb_read(ADDR_DATA, data, err);
		check_value("rx_data", data, 32'h0000_0022); // newest wins
		expected = '0;
		expected[STAT_RX_OVERRUN] = 1'b1;
		apb_write(ADDR_STATUS, expected, err); // write 1 clears
		apb_read(ADDR_STATUS, data, err);
		check_value("status", data, 32'd0);
	endtask

	task automatic loop_random_bytes();
		byte_t value;
		int unsigned rnd;
		for (int i = 0; i < 8; i++) begin
			rnd = $urandom;
			value = rnd[7:0];
			send_byte(value);
			expect_byte(value);
		end
	endtask

	//----------------------------------------------------------------------
	// main sequence
	//----------------------------------------------------------------------
	initial begin
		sys_clk = 1'b0;
		void'($urandom(32'hcafc8008));
		sys_rst <= 1'b1;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		repeat (10) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(posedge sys_clk);
		check_reset_state();
		run_loopback();
		measure_bit_timing();
		probe_errors();
		force_overrun();
		loop_random_bytes();
		if (u_uart_apb_top.u_checker.fail_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			abort_run("bound checker assertions failed during the run");
		end
	end

	// backstop in case a loop bound is ever raised too far
	initial begin
		repeat (200000) @(posedge sys_clk);
		abort_run("global watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

/* verif/uart_apb_checker.sv */
// bound into uart_apb_top; checks the zero-wait apb handshake and the line level after reset only
`timescale 1ns/1ps
`default_nettype none

module uart_apb_checker (
	input wire sys_clk,
	input wire sys_rst,
	input wire psel,
	input wire penable,
	input wire pready,
	input wire pslverr,
	input wire uart_txd
);

	int unsigned fail_count = 0; // failed assertions so far, read by the testbench

	//----------------------------------------------------------------------
	// apb handshake
	//----------------------------------------------------------------------
	// no wait states, every access phase completes at once
	pready_in_access: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(psel && penable) |-> pready)
		else begin
			fail_count++;
			$error("pready low during an apb access phase");
		end

	// error response only together with ready
	pslverr_with_ready: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pslverr |-> pready)
		else begin
			fail_count++;
			$error("pslverr raised while pready low");
		end

	//----------------------------------------------------------------------
	// serial line
	//----------------------------------------------------------------------
	txd_idle_after_reset: assert property (@(posedge sys_clk)
		$fell(sys_rst) |-> uart_txd) // idle mark level
		else begin
			fail_count++;
			$error("uart_txd not high in the first cycle after reset");
		end

endmodule

bind uart_apb_top uart_apb_checker u_checker (
	.sys_clk  (sys_clk),
	.sys_rst  (sys_rst),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.pslverr  (pslverr),
	.uart_txd (uart_txd)
);

`default_nettype wire
